/* verilog.f */
rtl/mixer_pkg.sv
rtl/ctrl_pkg.sv
rtl/axi_lite_regs.sv
rtl/seq_fsm.sv
rtl/axis_char_in.sv
rtl/emb_lookup.sv
rtl/mix_stage.sv
rtl/axis_char_out.sv
rtl/mixer_top.sv
tests/mixer_checker.sv
tests/tb_mixer_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the mixer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mixer_top -f verilog.f -o tb_mixer_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mixer_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if grep -q "TEST RESULT: FAIL" "$log"; then
  exit 1
fi
exit 0

/* tests/tb_mixer_top.sv */
`timescale 1ns/1ps

module tb_mixer_top;
  import mixer_pkg::*;
  import ctrl_pkg::*;

  // about a dozen packets at under 200 cycles each, with wide margin
  localparam int timeout_cycles = 20000;

  logic              clk;
  logic              rst_n;
  logic [3:0]        led_out;
  logic [addr_w-1:0] s_axi_awaddr;
  logic [2:0]        s_axi_awprot;
  logic              s_axi_awvalid;
  logic              s_axi_awready;
  logic [data_w-1:0] s_axi_wdata;
  logic [3:0]        s_axi_wstrb;
  logic              s_axi_wvalid;
  logic              s_axi_wready;
  logic [1:0]        s_axi_bresp;
  logic              s_axi_bvalid;
  logic              s_axi_bready;
  logic [addr_w-1:0] s_axi_araddr;
  logic [2:0]        s_axi_arprot;
  logic              s_axi_arvalid;
  logic              s_axi_arready;
  logic [data_w-1:0] s_axi_rdata;
  logic [1:0]        s_axi_rresp;
  logic              s_axi_rvalid;
  logic              s_axi_rready;
  char_t             s_axis_tdata;
  logic              s_axis_tlast;
  logic              s_axis_tvalid;
  logic              s_axis_tready;
  char_t             m_axis_tdata;
  logic              m_axis_tlast;
  logic              m_axis_tvalid;
  logic              m_axis_tready;

  integer      seed;
  int          cycle_cnt;
  string       test_name;
  char_t       chars [16];
  char_t       exp_bytes [n_tok];
  logic [31:0] rd_val;

  mixer_top i_dut (.*);

  bind mixer_top mixer_checker i_checker (
    .clk(clk), .rst_n(rst_n), .busy(busy), .led_out(led_out),
    .s_axi_awaddr(s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awready(s_axi_awready), .s_axi_wdata(s_axi_wdata),
    .s_axi_wstrb(s_axi_wstrb), .s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
    .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
    .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready),
    .s_axis_tdata(s_axis_tdata), .s_axis_tlast(s_axis_tlast),
    .s_axis_tvalid(s_axis_tvalid), .s_axis_tready(s_axis_tready),
    .m_axis_tdata(m_axis_tdata), .m_axis_tlast(m_axis_tlast),
    .m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp) else begin
      $display("mismatch %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, got);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping at first error");
    end
  endtask

  // ------------------------------
  // bus tasks
  // ------------------------------
  task automatic axi_write(input logic [addr_w-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    @(posedge clk);
    #1;
    while (!s_axi_awready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    while (!s_axi_bvalid) begin
      @(posedge clk);
      #1;
    end
    // responses are always okay
    check_value("bresp", 32'h0, 32'(s_axi_bresp));
    // one stalled cycle on the response
    @(posedge clk);
    #1;
    s_axi_bready = 1'b1;
    @(posedge clk);
    #1;
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [addr_w-1:0] addr, output logic [31:0] data);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    @(posedge clk);
    #1;
    while (!s_axi_arready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid) begin
      @(posedge clk);
      #1;
    end
    check_value("rresp", 32'h0, 32'(s_axi_rresp));
    @(posedge clk);
    #1;
    s_axi_rready = 1'b1;
    data         = s_axi_rdata;
    @(posedge clk);
    #1;
    s_axi_rready = 1'b0;
  endtask

  // ------------------------------
  // streams and model
  // ------------------------------
  task automatic fill_random(input int n);
    logic [31:0] rnd;
    for (int i = 0; i < n; i++) begin
      rnd      = $random(seed);
      chars[i] = rnd[7:0];
    end
  endtask

  // nibble features, then each pass adds the next token's old value
  task automatic build_expected(input int n, input int passes);
    int f [n_tok][emb_dim];
    int nf [n_tok][emb_dim];
    int c;
    for (int i = 0; i < n_tok; i++) begin
      c       = (i < n) ? int'(chars[i]) : 0;
      f[i][0] = (c % 16) - 8;
      f[i][1] = (c / 16) - 8;
    end
    for (int p = 0; p < passes; p++) begin
      for (int i = 0; i < n_tok; i++) begin
        for (int d = 0; d < emb_dim; d++) begin
          nf[i][d] = f[i][d] + f[(i + 1) % n_tok][d];
        end
      end
      f = nf;
    end
    for (int i = 0; i < n_tok; i++) begin
      exp_bytes[i] = char_t'((f[i][0] + f[i][1]) & 255);
    end
  endtask

  task automatic send_chars(input int n);
    for (int i = 0; i < n; i++) begin
      s_axis_tdata  = chars[i];
      s_axis_tlast  = (i == n - 1);
      s_axis_tvalid = 1'b1;
      while (!s_axis_tready) begin
        @(posedge clk);
        #1;
      end
      @(posedge clk);
      #1;
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
  endtask

  task automatic collect_bytes(input bit stall);
    int          got;
    logic [31:0] rnd;
    got = 0;
    while (got < n_tok) begin
      rnd           = $random(seed);
      m_axis_tready = stall ? (rnd[0] | rnd[1]) : 1'b1;
      if (m_axis_tvalid && m_axis_tready) begin
        check_value($sformatf("byte %0d", got), 32'(exp_bytes[got]), 32'(m_axis_tdata));
        check_value($sformatf("tlast %0d", got), 32'(got == n_tok - 1), 32'(m_axis_tlast));
        got++;
      end
      @(posedge clk);
      #1;
    end
    m_axis_tready = 1'b0;
  endtask

  // first beat is offered before start, so it waits on tready
  task automatic run_packet(input int n, input bit stall);
    logic [31:0] st;
    fork
      begin
        axi_write(reg_ctrl, 32'h1, 4'h1);
        axi_read(reg_status, st);
        check_value("status busy", 32'h2, st);
      end
      send_chars(n);
      collect_bytes(stall);
    join
    axi_read(reg_status, st);
    check_value("status finish", 32'h1, st);
  endtask

  initial begin
    seed          = 32'hb8b820e2;
    cycle_cnt     = 0;
    clk           = 1'b0;
    rst_n         = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awprot  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arprot  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tlast  = 1'b0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    test_name = "registers";
    axi_read(reg_status, rd_val);
    check_value("status idle", 32'h0, rd_val);
    axi_write(reg_mode, 32'h2, 4'h1);
    axi_read(reg_mode, rd_val);
    check_value("mode", 32'h2, rd_val);
    axi_write(reg_led, 32'ha, 4'h1);
    axi_read(reg_led, rd_val);
    check_value("led", 32'ha, rd_val);
    check_value("led_out", 32'ha, 32'(led_out));
    // lane 0 disabled, nothing may change
    axi_write(reg_led, 32'h5, 4'he);
    axi_write(reg_mode, 32'h1, 4'h0);
    axi_read(reg_led, rd_val);
    check_value("led kept", 32'ha, rd_val);
    check_value("led_out kept", 32'ha, 32'(led_out));
    axi_read(reg_mode, rd_val);
    check_value("mode kept", 32'h2, rd_val);
    axi_read(4'h6, rd_val);
    check_value("unmapped", 32'h0, rd_val);
    axi_read(reg_ctrl, rd_val);
    check_value("ctrl", 32'h0, rd_val);

    test_name = "full_packet";
    for (int m = 0; m < 4; m++) begin
      fill_random(n_tok);
      axi_write(reg_mode, 32'(m), 4'h1);
      build_expected(n_tok, m);
      run_packet(n_tok, 1'b0);
    end

    test_name = "short_packet";
    fill_random(5);
    axi_write(reg_mode, 32'h1, 4'h1);
    build_expected(5, 1);
    run_packet(5, 1'b0);

    test_name = "long_packet";
    fill_random(10);
    axi_write(reg_mode, 32'h2, 4'h1);
    build_expected(10, 2);
    run_packet(10, 1'b0);

    test_name = "backpressure";
    for (int m = 3; m > 0; m -= 2) begin
      fill_random(n_tok);
      axi_write(reg_mode, 32'(m), 4'h1);
      build_expected(n_tok, m);
      run_packet(n_tok, 1'b1);
    end

    test_name = "abort";
    axi_write(reg_ctrl, 32'h1, 4'h1);
    axi_read(reg_status, rd_val);
    check_value("status before abort", 32'h2, rd_val);
    axi_write(reg_ctrl, 32'h2, 4'h1);
    axi_read(reg_status, rd_val);
    check_value("status after abort", 32'h0, rd_val);
    fill_random(n_tok);
    axi_write(reg_mode, 32'h2, 4'h1);
    build_expected(n_tok, 2);
    run_packet(n_tok, 1'b1);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* tests/mixer_checker.sv */
`timescale 1ns/1ps

module mixer_checker (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        busy,
  input logic [3:0]                  led_out,
  input logic [ctrl_pkg::addr_w-1:0] s_axi_awaddr,
  input logic                        s_axi_awvalid,
  input logic                        s_axi_awready,
  input logic [ctrl_pkg::data_w-1:0] s_axi_wdata,
  input logic [3:0]                  s_axi_wstrb,
  input logic                        s_axi_wvalid,
  input logic                        s_axi_wready,
  input logic                        s_axi_bvalid,
  input logic                        s_axi_bready,
  input logic                        s_axi_rvalid,
  input logic                        s_axi_rready,
  input mixer_pkg::char_t            s_axis_tdata,
  input logic                        s_axis_tlast,
  input logic                        s_axis_tvalid,
  input logic                        s_axis_tready,
  input mixer_pkg::char_t            m_axis_tdata,
  input logic                        m_axis_tlast,
  input logic                        m_axis_tvalid,
  input logic                        m_axis_tready
);
  import ctrl_pkg::*;

  logic led_wr;

  // accepted write to the led register with lane 0 enabled
  assign led_wr = s_axi_awvalid && s_axi_awready && s_axi_wvalid && s_axi_wready &&
                  s_axi_wstrb[0] && (s_axi_awaddr == reg_led);

  // ------------------------------
  // stream stability
  // ------------------------------
  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else $error("output stream beat changed while stalled");

  in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axis_tvalid && !s_axis_tready |=>
      s_axis_tvalid && $stable(s_axis_tdata) && $stable(s_axis_tlast))
    else $error("input stream beat changed while stalled");

  // ------------------------------
  // bus responses
  // ------------------------------
  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else $error("bvalid dropped before bready");

  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
    else $error("rvalid dropped before rready");

  led_load: assert property (@(posedge clk) disable iff (!rst_n)
    led_wr |=> led_out == $past(s_axi_wdata[3:0]))
    else $error("led_out did not take the written value");

  led_keep: assert property (@(posedge clk) disable iff (!rst_n)
    !led_wr |=> $stable(led_out))
    else $error("led_out changed without a led write");

  // output only while a packet is in flight
  out_busy: assert property (@(posedge clk) disable iff (!rst_n)
    m_axis_tvalid |-> busy)
    else $error("output valid while not busy");

endmodule

/* rtl/mixer_top.sv */
`timescale 1ns/1ps

module mixer_top (
  input  logic                          clk,
  input  logic                          rst_n,
  output logic [3:0]                    led_out,
  input  logic [ctrl_pkg::addr_w-1:0]   s_axi_awaddr,
  input  logic [2:0]                    s_axi_awprot,
  input  logic                          s_axi_awvalid,
  output logic                          s_axi_awready,
  input  logic [ctrl_pkg::data_w-1:0]   s_axi_wdata,
  input  logic [ctrl_pkg::data_w/8-1:0] s_axi_wstrb,
  input  logic                          s_axi_wvalid,
  output logic                          s_axi_wready,
  output logic [1:0]                    s_axi_bresp,
  output logic                          s_axi_bvalid,
  input  logic                          s_axi_bready,
  input  logic [ctrl_pkg::addr_w-1:0]   s_axi_araddr,
  input  logic [2:0]                    s_axi_arprot,
  input  logic                          s_axi_arvalid,
  output logic                          s_axi_arready,
  output logic [ctrl_pkg::data_w-1:0]   s_axi_rdata,
  output logic [1:0]                    s_axi_rresp,
  output logic                          s_axi_rvalid,
  input  logic                          s_axi_rready,
  input  mixer_pkg::char_t              s_axis_tdata,
  input  logic                          s_axis_tlast,
  input  logic                          s_axis_tvalid,
  output logic                          s_axis_tready,
  output mixer_pkg::char_t              m_axis_tdata,
  output logic                          m_axis_tlast,
  output logic                          m_axis_tvalid,
  input  logic                          m_axis_tready
);
  import mixer_pkg::*;
  import ctrl_pkg::*;

  // ------------------------------
  // control
  // ------------------------------
  logic  start_pulse;
  logic  abort_pulse;
  logic  finish;
  logic  busy;
  mode_t mode;

  // ------------------------------
  // stage handshakes and data
  // ------------------------------
  logic  recv_en;
  logic  seq_valid;
  seq_t  seq;
  logic  emb_start;
  logic  emb_valid;
  feat_t emb;
  logic  mix_load;
  logic  mix_start;
  logic  pass_done;
  feat_t feat;
  logic  send_start;
  logic  send_done;

  axi_lite_regs i_regs (
    .clk, .rst_n,
    .s_axi_awaddr, .s_axi_awprot, .s_axi_awvalid, .s_axi_awready,
    .s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
    .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
    .s_axi_araddr, .s_axi_arprot, .s_axi_arvalid, .s_axi_arready,
    .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
    .finish, .busy, .start_pulse, .abort_pulse, .mode, .led_out
  );

  seq_fsm i_fsm (
    .clk, .rst_n, .start_pulse, .abort_pulse, .mode,
    .seq_valid, .emb_valid, .pass_done, .send_done,
    .recv_en, .emb_start, .mix_load, .mix_start, .send_start, .finish, .busy
  );

  axis_char_in i_char_in (
    .clk, .rst_n, .s_axis_tdata, .s_axis_tlast, .s_axis_tvalid, .s_axis_tready,
    .recv_en, .seq_valid, .seq
  );

  emb_lookup i_emb (
    .clk, .rst_n, .emb_start, .seq, .emb_valid, .emb
  );

  // load from embedding or keep the previous pass result
  mix_stage i_mix (
    .clk, .rst_n, .mix_load, .mix_start, .emb, .pass_done, .feat
  );

  axis_char_out i_char_out (
    .clk, .rst_n, .send_start, .feat,
    .m_axis_tdata, .m_axis_tlast, .m_axis_tvalid, .m_axis_tready, .send_done
  );

endmodule

/* rtl/axis_char_out.sv */
`timescale 1ns/1ps

module axis_char_out (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             send_start,
  input  mixer_pkg::feat_t feat,
  output mixer_pkg::char_t m_axis_tdata,
  output logic             m_axis_tlast,
  output logic             m_axis_tvalid,
  input  logic             m_axis_tready,
  output logic             send_done
);
  import mixer_pkg::*;

  idx_t idx;
  num_t f0;
  num_t f1;
  logic last;
  logic beat;

  // byte is the low half of the feature sum, idx holds under back-pressure
  assign f0           = feat[(idx*emb_dim)*num_w +: num_w];
  assign f1           = feat[(idx*emb_dim + 1)*num_w +: num_w];
  assign m_axis_tdata = char_t'(f0 + f1);

  assign last         = (idx == idx_t'(n_tok - 1));
  assign m_axis_tlast = m_axis_tvalid && last;
  assign beat         = m_axis_tvalid && m_axis_tready;
  assign send_done    = beat && last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_axis_tvalid <= 1'b0;
      idx           <= '0;
    end else if (send_start) begin
      m_axis_tvalid <= 1'b1;
      idx           <= '0;
    end else if (beat) begin
      if (last) begin
        m_axis_tvalid <= 1'b0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

endmodule

/* rtl/mix_stage.sv */
`timescale 1ns/1ps

module mix_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             mix_load,
  input  logic             mix_start,
  input  mixer_pkg::feat_t emb,
  output logic             pass_done,
  output mixer_pkg::feat_t feat
);
  import mixer_pkg::*;

  feat_t snap;
  idx_t  pos;
  idx_t  nxt;
  logic  active;

  // neighbour index wraps at n_tok
  assign nxt       = pos + 1'b1;
  assign pass_done = active && (pos == idx_t'(n_tok - 1));

  // ------------------------------
  // pass sequencing
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      pos    <= '0;
    end else if (mix_start) begin
      active <= 1'b1;
      pos    <= '0;
    end else if (active) begin
      pos <= nxt;
      if (pass_done) begin
        active <= 1'b0;
      end
    end
  end

  // ------------------------------
  // working bank
  // ------------------------------
  // snapshot keeps the whole pass reading pre-pass values
  always_ff @(posedge clk) begin
    if (mix_start) begin
      snap <= feat;
    end
  end

  always_ff @(posedge clk) begin
    if (mix_load) begin
      feat <= emb;
    end else if (active) begin
      for (int d = 0; d < emb_dim; d++) begin
        feat[(pos*emb_dim + d)*num_w +: num_w] <=
          snap[(pos*emb_dim + d)*num_w +: num_w] + snap[(nxt*emb_dim + d)*num_w +: num_w];
      end
    end
  end

endmodule

/* rtl/emb_lookup.sv */
`timescale 1ns/1ps

module emb_lookup (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             emb_start,
  input  mixer_pkg::seq_t  seq,
  output logic             emb_valid,
  output mixer_pkg::feat_t emb
);
  import mixer_pkg::*;

  // nibble minus 8 is the nibble with its top bit flipped, read as signed
  function automatic num_t nib_feat(input logic [3:0] nib);
    logic [3:0] s;
    s = {~nib[3], nib[2:0]};
    return num_t'($signed(s));
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      emb_valid <= 1'b0;
    end else begin
      emb_valid <= emb_start;
    end
  end

  always_ff @(posedge clk) begin
    if (emb_start) begin
      for (int i = 0; i < n_tok; i++) begin
        emb[(i*emb_dim)*num_w +: num_w]     <= nib_feat(seq[i*char_w +: 4]);
        emb[(i*emb_dim + 1)*num_w +: num_w] <= nib_feat(seq[i*char_w + 4 +: 4]);
      end
    end
  end

endmodule

/* rtl/axis_char_in.sv */
`timescale 1ns/1ps

module axis_char_in (
  input  logic             clk,
  input  logic             rst_n,
  input  mixer_pkg::char_t s_axis_tdata,
  input  logic             s_axis_tlast,
  input  logic             s_axis_tvalid,
  output logic             s_axis_tready,
  input  logic             recv_en,
  output logic             seq_valid,
  output mixer_pkg::seq_t  seq
);
  import mixer_pkg::*;

  logic recv_q;
  logic fresh;
  logic done;
  logic full;
  logic beat;
  idx_t cnt;

  // first cycle of RECV only clears the buffer
  assign fresh         = recv_en && !recv_q;
  assign s_axis_tready = recv_en && !fresh && !done;
  assign beat          = s_axis_tvalid && s_axis_tready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      recv_q    <= 1'b0;
      done      <= 1'b0;
      full      <= 1'b0;
      cnt       <= '0;
      seq_valid <= 1'b0;
    end else begin
      recv_q    <= recv_en;
      seq_valid <= 1'b0;
      if (fresh) begin
        done <= 1'b0;
        full <= 1'b0;
        cnt  <= '0;
      end else if (beat) begin
        if (!full) begin
          cnt <= cnt + 1'b1;
          if (cnt == idx_t'(n_tok - 1)) full <= 1'b1;
        end
        // packet ends on tlast, beats past the eighth are dropped
        if (s_axis_tlast) begin
          done      <= 1'b1;
          seq_valid <= 1'b1;
        end
      end
    end
  end

  // missing tokens stay zero
  always_ff @(posedge clk) begin
    if (fresh) begin
      seq <= '0;
    end else if (beat && !full) begin
      seq[cnt*char_w +: char_w] <= s_axis_tdata;
    end
  end

endmodule

/* rtl/seq_fsm.sv */
`timescale 1ns/1ps

module seq_fsm (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_pulse,
  input  logic            abort_pulse,
  input  ctrl_pkg::mode_t mode,
  input  logic            seq_valid,
  input  logic            emb_valid,
  input  logic            pass_done,
  input  logic            send_done,
  output logic            recv_en,
  output logic            emb_start,
  output logic            mix_load,
  output logic            mix_start,
  output logic            send_start,
  output logic            finish,
  output logic            busy
);
  import ctrl_pkg::*;

  state_t state;
  mode_t  pass_cnt;
  mode_t  pass_nxt;

  assign pass_nxt = pass_cnt + 1'b1;
  assign recv_en  = (state == RECV);
  assign mix_load = (state == LOAD);
  assign finish   = (state == FIN);
  assign busy     = (state != IDLE) && (state != FIN);

  // start pulses are registered so each lands in the first cycle of its state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      pass_cnt   <= '0;
      emb_start  <= 1'b0;
      mix_start  <= 1'b0;
      send_start <= 1'b0;
    end else begin
      emb_start  <= 1'b0;
      mix_start  <= 1'b0;
      send_start <= 1'b0;
      if (abort_pulse) begin
        state <= IDLE;
      end else begin
        case (state)
          IDLE, FIN: if (start_pulse) state <= RECV;
          RECV: begin
            if (seq_valid) begin
              state     <= EMB;
              emb_start <= 1'b1;
            end
          end
          EMB: if (emb_valid) state <= LOAD;
          LOAD: begin
            pass_cnt <= '0;
            if (mode == '0) begin
              state      <= SEND;
              send_start <= 1'b1;
            end else begin
              state     <= MIX;
              mix_start <= 1'b1;
            end
          end
          MIX: begin
            if (pass_done) begin
              pass_cnt <= pass_nxt;
              if (pass_nxt == mode) begin
                state      <= SEND;
                send_start <= 1'b1;
              end else begin
                mix_start <= 1'b1;
              end
            end
          end
          SEND: if (send_done) state <= FIN;
          default: state <= IDLE;
        endcase
      end
    end
  end

endmodule

/* rtl/axi_lite_regs.sv */
`timescale 1ns/1ps

module axi_lite_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [ctrl_pkg::addr_w-1:0]   s_axi_awaddr,
  input  logic [2:0]                    s_axi_awprot,
  input  logic                          s_axi_awvalid,
  output logic                          s_axi_awready,
  input  logic [ctrl_pkg::data_w-1:0]   s_axi_wdata,
  input  logic [ctrl_pkg::data_w/8-1:0] s_axi_wstrb,
  input  logic                          s_axi_wvalid,
  output logic                          s_axi_wready,
  output logic [1:0]                    s_axi_bresp,
  output logic                          s_axi_bvalid,
  input  logic                          s_axi_bready,
  input  logic [ctrl_pkg::addr_w-1:0]   s_axi_araddr,
  input  logic [2:0]                    s_axi_arprot,
  input  logic                          s_axi_arvalid,
  output logic                          s_axi_arready,
  output logic [ctrl_pkg::data_w-1:0]   s_axi_rdata,
  output logic [1:0]                    s_axi_rresp,
  output logic                          s_axi_rvalid,
  input  logic                          s_axi_rready,
  input  logic                          finish,
  input  logic                          busy,
  output logic                          start_pulse,
  output logic                          abort_pulse,
  output ctrl_pkg::mode_t               mode,
  output logic [3:0]                    led_out
);
  import ctrl_pkg::*;

  logic              wr_rdy;
  logic              wr_fire;
  logic              rd_fire;
  logic [data_w-1:0] rd_mux;

  // address and data are accepted together, prot bits ignored
  assign s_axi_awready = wr_rdy;
  assign s_axi_wready  = wr_rdy;
  assign s_axi_bresp   = resp_okay;
  assign s_axi_rresp   = resp_okay;

  assign wr_fire = wr_rdy && s_axi_awvalid && s_axi_wvalid;
  assign rd_fire = s_axi_arready && s_axi_arvalid;

  // ------------------------------
  // write channel
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_rdy       <= 1'b0;
      s_axi_bvalid <= 1'b0;
      start_pulse  <= 1'b0;
      abort_pulse  <= 1'b0;
      mode         <= '0;
      led_out      <= '0;
    end else begin
      start_pulse <= 1'b0;
      abort_pulse <= 1'b0;
      wr_rdy      <= s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !wr_rdy;
      if (wr_fire) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
      // only byte lane 0 holds register bits
      if (wr_fire && s_axi_wstrb[0]) begin
        case (s_axi_awaddr)
          reg_ctrl: begin
            start_pulse <= s_axi_wdata[0];
            abort_pulse <= s_axi_wdata[1];
          end
          reg_mode: mode    <= mode_t'(s_axi_wdata[1:0]);
          reg_led:  led_out <= s_axi_wdata[3:0];
          default:  ;
        endcase
      end
    end
  end

  // ------------------------------
  // read channel
  // ------------------------------
  always_comb begin
    case (s_axi_araddr)
      reg_mode:   rd_mux = data_w'(mode);
      reg_status: rd_mux = data_w'({busy, finish});
      reg_led:    rd_mux = data_w'(led_out);
      // ctrl bits are pulses and read back as zero
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
    end else begin
      s_axi_arready <= s_axi_arvalid && !s_axi_arready && !s_axi_rvalid;
      if (rd_fire) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      s_axi_rdata <= rd_mux;
    end
  end

endmodule

/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

  // ------------------------------
  // sequencer
  // ------------------------------
  typedef enum logic [2:0] {
    IDLE,
    RECV,
    EMB,
    LOAD,
    MIX,
    SEND,
    FIN
  } state_t;

  // ------------------------------
  // register port
  // ------------------------------
  localparam int addr_w = 4;
  localparam int data_w = 32;

  localparam logic [addr_w-1:0] reg_ctrl   = 'h0;
  localparam logic [addr_w-1:0] reg_mode   = 'h4;
  localparam logic [addr_w-1:0] reg_status = 'h8;
  localparam logic [addr_w-1:0] reg_led    = 'hC;

  localparam logic [1:0] resp_okay = 2'b00;

  // number of mix passes
  typedef logic [1:0] mode_t;

endpackage

/* rtl/mixer_pkg.sv */
package mixer_pkg;

  // ------------------------------
  // packet geometry
  // ------------------------------
  localparam int n_tok   = 8;
  localparam int char_w  = 8;
  localparam int emb_dim = 2;
  localparam int num_w   = 16;

  // ------------------------------
  // datapath vectors
  // ------------------------------
  typedef logic [char_w-1:0] char_t;
  typedef logic signed [num_w-1:0] num_t;

  // token i in bits [i*char_w +: char_w]
  typedef logic [n_tok*char_w-1:0] seq_t;

  // feature d of token i at slot i*emb_dim + d
  typedef logic [n_tok*emb_dim*num_w-1:0] feat_t;

  typedef logic [$clog2(n_tok)-1:0] idx_t;

endpackage
